/* source/layer_macros.svh */
`ifndef LAYER_MACROS_SVH
`define LAYER_MACROS_SVH

// activation/weight pairs per item
`define LANES 24

// lanes reduced by one processing element
`define PE_LANES 8

// processing elements feeding the second stage
`define PE_COUNT 3

// data word width, signed fixed point
`define WORD_W 32

// fractional bits of the fixed-point format
`define FRAC_BITS 15

// partial-sum buffer entries, also the producer's starting credit
`define FIFO_DEPTH 4

// result slots in the reduce stage, also the buffer's starting credit
`define OUT_SLOTS 2

`endif

/* source/layer_data_pkg.sv */
`include "layer_macros.svh"

package layer_data_pkg;

  // one signed fixed-point word
  typedef logic signed [`WORD_W-1:0] word_t;

  // all lanes of one item
  // used for activations, weights and the scaled products
  typedef word_t [`LANES-1:0] lane_vec_t;

  // one partial sum per processing element
  // index k covers lanes k*PE_LANES up to k*PE_LANES+PE_LANES-1
  typedef word_t [`PE_COUNT-1:0] partial_set_t;

endpackage

/* source/layer_ctrl_pkg.sv */
package layer_ctrl_pkg;

  // activation applied to the reduced total
  // relu clamps negative totals to zero
  typedef enum logic {
    OP_NONE = 1'b0,
    OP_RELU = 1'b1
  } act_op_t;

endpackage

/* source/partial_if.sv */
`timescale 1ns/1ps

interface partial_if
  import layer_data_pkg::*, layer_ctrl_pkg::*;
();

  // one-cycle beat, only sent while the sender holds a credit
  logic         valid;
  // partial sums of one item
  partial_set_t partials;
  // activation carried along with the item
  act_op_t      op;
  // receiver frees one entry, single-cycle pulse
  logic         credit;

  // sending side keeps the credit counter
  modport src (
    output valid,
    output partials,
    output op,
    input  credit
  );

  // receiving side returns credits as entries drain
  modport dst (
    input  valid,
    input  partials,
    input  op,
    output credit
  );

endinterface

/* source/dot_stage.sv */
`timescale 1ns/1ps
`include "layer_macros.svh"

module dot_stage
  import layer_data_pkg::*, layer_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      i_reset,
  input  logic      i_in_valid,
  output logic      o_in_ready,
  input  act_op_t   i_op,
  input  lane_vec_t i_act,
  input  lane_vec_t i_wgt,
  partial_if.src    link
);

  localparam int CRD_W = $clog2(`FIFO_DEPTH + 1);

  // credits toward the partial-sum buffer
  logic [CRD_W-1:0] crd_cnt;
  logic             accept;

  // scaled products, combinational
  lane_vec_t prod;

  // stage 1 registers
  lane_vec_t s1_prod;
  act_op_t   s1_op;
  logic      s1_valid;

  // full 64-bit product, arithmetic shift, keep low word
  function automatic word_t mul_shift(input word_t a, input word_t b);
    logic signed [2*`WORD_W-1:0] full;
    full = a * b;
    return word_t'(full >>> `FRAC_BITS);
  endfunction

  // one PE: wrapping sum over its slice of lanes
  function automatic word_t pe_sum(input lane_vec_t p, input int pe);
    word_t acc;
    acc = '0;
    for (int j = 0; j < `PE_LANES; j++) begin
      acc = acc + p[pe*`PE_LANES + j];
    end
    return acc;
  endfunction

  // ready only while a buffer entry is reserved for us
  assign o_in_ready = (crd_cnt != '0);
  assign accept     = i_in_valid && o_in_ready;

  // credit spent at acceptance, so pipeline contents are covered
  always_ff @(posedge clk) begin
    if (i_reset) begin
      crd_cnt <= CRD_W'(`FIFO_DEPTH);
    end else begin
      crd_cnt <= crd_cnt - CRD_W'(accept) + CRD_W'(link.credit);
    end
  end

  always_comb begin
    for (int i = 0; i < `LANES; i++) begin
      prod[i] = mul_shift(i_act[i], i_wgt[i]);
    end
  end

  // stage 1: products plus opcode
  always_ff @(posedge clk) begin
    if (i_reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= accept;
    end
    if (accept) begin
      s1_prod <= prod;
      s1_op   <= i_op;
    end
  end

  // stage 2: three PE sums straight onto the link
  always_ff @(posedge clk) begin
    if (i_reset) begin
      link.valid <= 1'b0;
    end else begin
      link.valid <= s1_valid;
    end
    if (s1_valid) begin
      for (int k = 0; k < `PE_COUNT; k++) begin
        link.partials[k] <= pe_sum(s1_prod, k);
      end
      link.op <= s1_op;
    end
  end

  // buffer must never hand back more credits than it has entries
  a_crd_bound: assert property (
    @(posedge clk) disable iff (i_reset) crd_cnt <= CRD_W'(`FIFO_DEPTH)
  );

endmodule

/* source/partial_fifo.sv */
`timescale 1ns/1ps
`include "layer_macros.svh"

module partial_fifo
  import layer_data_pkg::*, layer_ctrl_pkg::*;
(
  input logic    clk,
  input logic    i_reset,
  partial_if.dst link_in,
  partial_if.src link_out
);

  localparam int PTR_W = $clog2(`FIFO_DEPTH);
  localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);
  localparam int CRD_W = $clog2(`OUT_SLOTS + 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`FIFO_DEPTH);

  // entry storage, sums and opcode side by side
  partial_set_t mem_parts [`FIFO_DEPTH];
  act_op_t      mem_op    [`FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // credits toward the reduce stage slots
  logic [CRD_W-1:0] out_crd;

  logic wr_en;
  logic send;

  // every beat is taken, the producer already holds a credit
  assign wr_en = link_in.valid;
  // head leaves when present and a slot is reserved downstream
  assign send  = (count != '0) && (out_crd != '0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_parts[wr_ptr] <= link_in.partials;
      mem_op[wr_ptr]    <= link_in.op;
    end
  end

  // pointers and fill level
  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(wr_en) - CNT_W'(send);
    end
  end

  // outgoing beat registered, upstream credit goes out with it
  always_ff @(posedge clk) begin
    if (i_reset) begin
      link_out.valid <= 1'b0;
      link_in.credit <= 1'b0;
      out_crd        <= CRD_W'(`OUT_SLOTS);
    end else begin
      link_out.valid <= send;
      link_in.credit <= send;
      out_crd        <= out_crd - CRD_W'(send) + CRD_W'(link_out.credit);
    end
    if (send) begin
      link_out.partials <= mem_parts[rd_ptr];
      link_out.op       <= mem_op[rd_ptr];
    end
  end

  // producer credits keep writes away from a full buffer
  a_no_overflow: assert property (
    @(posedge clk) disable iff (i_reset) link_in.valid |-> count != FULL_CNT
  );

  // reduce stage returns at most one credit per slot
  a_crd_bound: assert property (
    @(posedge clk) disable iff (i_reset) out_crd <= CRD_W'(`OUT_SLOTS)
  );

endmodule

/* source/reduce_stage.sv */
`timescale 1ns/1ps
`include "layer_macros.svh"

module reduce_stage
  import layer_data_pkg::*, layer_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   i_reset,
  partial_if.dst link,
  output logic   o_out_valid,
  input  logic   i_out_ready,
  output word_t  o_out_data
);

  localparam int PTR_W = $clog2(`OUT_SLOTS);
  localparam int CNT_W = $clog2(`OUT_SLOTS + 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`OUT_SLOTS);

  // result queue, head goes to the output
  word_t slots [`OUT_SLOTS];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  word_t total;
  word_t result;
  logic  pop;

  // second stage: wrapping sum of the PE outputs
  always_comb begin
    total = '0;
    for (int k = 0; k < `PE_COUNT; k++) begin
      total = total + link.partials[k];
    end
  end

  // relu keeps positives, negatives become zero
  always_comb begin
    if (link.op == OP_RELU && total < 0) begin
      result = '0;
    end else begin
      result = total;
    end
  end

  assign o_out_valid = (count != '0);
  assign o_out_data  = slots[rd_ptr];
  assign pop         = o_out_valid && i_out_ready;

  // a slot freed at the handshake goes back as a credit
  assign link.credit = pop;

  // slot written the cycle after the link beat
  always_ff @(posedge clk) begin
    if (link.valid) begin
      slots[wr_ptr] <= result;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (link.valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(link.valid) - CNT_W'(pop);
    end
  end

  // held result must not move until the sink takes it
  a_stall_stable: assert property (
    @(posedge clk) disable iff (i_reset)
      (o_out_valid && !i_out_ready) |=> (o_out_valid && $stable(o_out_data))
  );

  // buffer credits keep beats away from full slots
  a_no_overflow: assert property (
    @(posedge clk) disable iff (i_reset) link.valid |-> count != FULL_CNT
  );

endmodule

/* source/conv_layer_top.sv */
`timescale 1ns/1ps

module conv_layer_top
  import layer_data_pkg::*, layer_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      i_reset,
  input  logic      i_in_valid,
  output logic      o_in_ready,
  input  act_op_t   i_op,
  input  lane_vec_t i_act,
  input  lane_vec_t i_wgt,
  output logic      o_out_valid,
  input  logic      i_out_ready,
  output word_t     o_out_data
);

  // producer to buffer
  partial_if link_pf ();
  // buffer to reduce stage
  partial_if link_fr ();

  // products and the three PE partial sums
  dot_stage u_dot (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_in_valid (i_in_valid),
    .o_in_ready (o_in_ready),
    .i_op       (i_op),
    .i_act      (i_act),
    .i_wgt      (i_wgt),
    .link       (link_pf.src)
  );

  // absorbs partials while the output is stalled
  partial_fifo u_fifo (
    .clk      (clk),
    .i_reset  (i_reset),
    .link_in  (link_pf.dst),
    .link_out (link_fr.src)
  );

  // final sum, activation, output queue
  reduce_stage u_reduce (
    .clk         (clk),
    .i_reset     (i_reset),
    .link        (link_fr.dst),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .o_out_data  (o_out_data)
  );

endmodule

/* tests/conv_layer_tb.sv */
`timescale 1ns/1ps
`include "layer_macros.svh"

module conv_layer_tb
  import layer_data_pkg::*, layer_ctrl_pkg::*;
();

  logic      clk;
  logic      i_reset;
  logic      i_in_valid;
  logic      o_in_ready;
  act_op_t   i_op;
  lane_vec_t i_act;
  lane_vec_t i_wgt;
  logic      o_out_valid;
  logic      i_out_ready;
  word_t     o_out_data;

  // scoreboard of expected results in acceptance order
  word_t exp_q [$];
  string test_name;

  // sink behavior
  logic  bp_mode;
  int    stall_left;
  logic  was_stalled;
  word_t held_data;
  logic  saw_not_ready;

  // item currently offered on the input side
  lane_vec_t cur_act;
  lane_vec_t cur_wgt;
  act_op_t   cur_op;
  word_t     cur_exp;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  conv_layer_top DUT (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_in_valid  (i_in_valid),
    .o_in_ready  (o_in_ready),
    .i_op        (i_op),
    .i_act       (i_act),
    .i_wgt       (i_wgt),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .o_out_data  (o_out_data)
  );

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_error(input string what);
    $display("ERROR in %s: %s", test_name, what);
    stop_run();
  endtask

  task automatic check_word(input string label, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("CHECK FAILED test=%s check=%s expected=0x%08h actual=0x%08h",
               test_name, label, exp, act);
      stop_run();
    end
  endtask

  task automatic check_flag(input string label, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED test=%s check=%s expected=%b actual=%b",
               test_name, label, exp, act);
      stop_run();
    end
  endtask

  // reference model with full 64-bit products shifted by frac bits and a wrapping sum
  function automatic word_t expected_output(input lane_vec_t a, input lane_vec_t w,
                                            input act_op_t op);
    longint p;
    word_t  acc;
    acc = '0;
    for (int i = 0; i < `LANES; i++) begin
      p   = longint'(a[i]) * longint'(w[i]);
      acc = acc + word_t'(p >>> `FRAC_BITS);
    end
    // relu clamps negative totals
    if (op == OP_RELU && acc < 0) begin
      acc = '0;
    end
    return acc;
  endfunction

  // with unit weights the layer is just a wrapping sum
  function automatic word_t act_sum(input lane_vec_t a);
    word_t acc;
    acc = '0;
    for (int i = 0; i < `LANES; i++) begin
      acc = acc + a[i];
    end
    return acc;
  endfunction

  // shift narrows the magnitude and keeps the sign
  function automatic lane_vec_t random_vec(input int shift);
    lane_vec_t v;
    for (int i = 0; i < `LANES; i++) begin
      v[i] = word_t'($urandom) >>> shift;
    end
    return v;
  endfunction

  function automatic lane_vec_t unit_weights();
    lane_vec_t v;
    for (int i = 0; i < `LANES; i++) begin
      v[i] = word_t'(1 << `FRAC_BITS);
    end
    return v;
  endfunction

  // long random stalls in back-pressure mode and mostly ready otherwise
  task automatic choose_ready(output logic rdy);
    if (bp_mode) begin
      if (stall_left > 0) begin
        stall_left--;
        rdy = 1'b0;
      end else if ($urandom % 8 == 0) begin
        stall_left = 20 + int'($urandom % 40);
        rdy = 1'b0;
      end else begin
        rdy = 1'b1;
      end
    end else begin
      rdy = ($urandom % 4 != 0);
    end
  endtask

  // one clock of driving at negedge and counting the handshakes of the next posedge
  // ready and valid come from DUT registers and are settled here
  task automatic step_cycle(input logic want_in, output logic took);
    logic  rdy;
    word_t exp;
    @(negedge clk);
    if (was_stalled) begin
      check_flag("valid held while stalled", 1'b1, o_out_valid);
      check_word("data held while stalled", held_data, o_out_data);
    end
    choose_ready(rdy);
    i_in_valid  = want_in;
    i_act       = cur_act;
    i_wgt       = cur_wgt;
    i_op        = cur_op;
    i_out_ready = rdy;
    if (!o_in_ready) begin
      saw_not_ready = 1'b1;
    end
    // output side first so a fresh item never matches itself
    if (o_out_valid && rdy) begin
      if (exp_q.size() == 0) begin
        report_error("output handshake while no result was expected");
      end
      exp = exp_q.pop_front();
      check_word("result", exp, o_out_data);
    end
    took = want_in && o_in_ready;
    if (took) begin
      exp_q.push_back(cur_exp);
    end
    was_stalled = o_out_valid && !rdy;
    held_data   = o_out_data;
  endtask

  task automatic send_item(input lane_vec_t a, input lane_vec_t w, input act_op_t op,
                           input word_t exp);
    logic took;
    int   waited;
    cur_act = a;
    cur_wgt = w;
    cur_op  = op;
    cur_exp = exp;
    took    = 1'b0;
    waited  = 0;
    while (!took) begin
      if (waited == 1000) begin
        report_error("timeout waiting for o_in_ready");
      end
      step_cycle(1'b1, took);
      waited++;
    end
  endtask

  // run until every expected result came out and then idle for strays
  task automatic drain();
    logic took;
    int   waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited == 5000) begin
        report_error("timeout waiting for outstanding results");
      end
      step_cycle(1'b0, took);
      waited++;
    end
    repeat (12) step_cycle(1'b0, took);
  endtask

  initial begin
    lane_vec_t a;
    lane_vec_t w;
    act_op_t   op;
    void'($urandom(32'hdee3));
    i_reset     = 1'b1;
    i_in_valid  = 1'b0;
    i_out_ready = 1'b0;
    i_op        = OP_NONE;
    i_act       = '0;
    i_wgt       = '0;
    cur_act     = '0;
    cur_wgt     = '0;
    cur_op      = OP_NONE;
    cur_exp     = '0;
    bp_mode     = 1'b0;
    stall_left  = 0;
    was_stalled = 1'b0;
    held_data   = '0;
    // output stays quiet while reset is held for 10 cycles
    test_name = "reset";
    for (int n = 0; n < 10; n++) begin
      @(negedge clk);
      check_flag("out_valid during reset", 1'b0, o_out_valid);
    end
    i_reset = 1'b0;
    @(negedge clk);
    check_flag("out_valid after reset", 1'b0, o_out_valid);
    check_flag("in_ready after reset", 1'b1, o_in_ready);

    test_name = "identity";
    for (int n = 0; n < 16; n++) begin
      a = random_vec(4);
      send_item(a, unit_weights(), OP_NONE, act_sum(a));
    end
    drain();

    test_name = "random";
    for (int n = 0; n < 200; n++) begin
      a = random_vec(0);
      w = random_vec(0);
      send_item(a, w, OP_NONE, expected_output(a, w, OP_NONE));
    end
    drain();

    // smaller magnitudes so totals land on both sides of zero
    test_name = "relu";
    for (int n = 0; n < 120; n++) begin
      a  = random_vec(8);
      w  = random_vec(8);
      op = ($urandom % 2 == 0) ? OP_NONE : OP_RELU;
      send_item(a, w, op, expected_output(a, w, op));
    end
    drain();

    test_name     = "backpressure";
    bp_mode       = 1'b1;
    saw_not_ready = 1'b0;
    for (int n = 0; n < 150; n++) begin
      a  = random_vec(6);
      w  = random_vec(6);
      op = ($urandom % 2 == 0) ? OP_NONE : OP_RELU;
      send_item(a, w, op, expected_output(a, w, op));
    end
    drain();
    check_flag("in_ready dropped under stall", 1'b1, saw_not_ready);
    bp_mode = 1'b0;

    // sink ready again, any result still held would be an extra one
    test_name = "totals";
    drain();
    if (o_out_valid) begin
      report_error("result left in the DUT after all accepted items came out");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

/* list.f */
+incdir+source
source/layer_data_pkg.sv
source/layer_ctrl_pkg.sv
source/partial_if.sv
source/dot_stage.sv
source/partial_fifo.sv
source/reduce_stage.sv
source/conv_layer_top.sv
tests/conv_layer_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the layer testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f list.f \
  --top-module conv_layer_tb \
  -Mdir obj_dir \
  -o conv_layer_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed"
  exit 1
fi

./obj_dir/conv_layer_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Test failed" "$SIM_LOG"; then
  echo "simulation reported a failure"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

echo "simulation passed"
exit 0
